// File: src/cia_map_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CIA register map and bit positions
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cia_map_pkg;

    // Register addresses on the 4-bit bus.
    localparam logic [3:0] REG_PRA   = 4'h0;
    localparam logic [3:0] REG_PRB   = 4'h1;
    localparam logic [3:0] REG_DDRA  = 4'h2;
    localparam logic [3:0] REG_DDRB  = 4'h3;
    localparam logic [3:0] REG_TA_LO = 4'h4;
    localparam logic [3:0] REG_TA_HI = 4'h5;
    localparam logic [3:0] REG_TB_LO = 4'h6;
    localparam logic [3:0] REG_TB_HI = 4'h7;
    localparam logic [3:0] REG_ICR   = 4'hD;
    localparam logic [3:0] REG_CRA   = 4'hE;
    localparam logic [3:0] REG_CRB   = 4'hF;

    // Control register bits, shared by CRA and CRB.
    localparam int CR_START     = 0;
    localparam int CR_ONESHOT   = 3;
    localparam int CR_LOAD      = 4;
    localparam int CR_INMODE_TA = 6;

    // Mask write selects set (1) or clear (0).
    localparam int ICR_SET_CLR = 7;

    // Interrupt source positions.
    localparam int IRQ_TA   = 0;
    localparam int IRQ_TB   = 1;
    localparam int IRQ_FLAG = 4;
    localparam int IRQ_BITS = 5;

endpackage

// File: src/cia_types_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CIA internal bus types
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cia_types_pkg;

    // Write cycle, one strobe per address.
    typedef struct packed {
        logic [15:0] strobe;
        logic [7:0]  data;
    } cia_wr_t;

    // Read cycle, one strobe per address.
    typedef struct packed {
        logic [15:0] strobe;
    } cia_rd_t;

    // Register writes seen by one timer.
    typedef struct packed {
        logic       lo_wr;
        logic       hi_wr;
        logic       cr_wr;
        logic [7:0] data;
    } timer_bus_t;

    // Timer state as seen by the rest of the chip.
    typedef struct packed {
        logic [15:0] counter;
        logic        running;
        logic        oneshot;
        // Count the other timer's underflows.
        logic        count_uf;
        logic        underflow;
    } timer_state_t;

    // Interrupt source pulses, one cycle each.
    typedef struct packed {
        logic [cia_map_pkg::IRQ_BITS-1:0] pulse;
    } irq_src_t;

endpackage

// File: src/cia_bus_decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CIA bus cycle decoder
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module cia_bus_decode (
    input  logic                   cs_n,
    input  logic                   rw,
    input  logic [3:0]             a,
    input  logic [7:0]             d_in,
    output cia_types_pkg::cia_wr_t wr,
    output cia_types_pkg::cia_rd_t rd
);

    logic [15:0] addr_hot;
    logic        wr_cycle;
    logic        rd_cycle;

    // One-hot address.
    always_comb begin
        addr_hot    = '0;
        addr_hot[a] = 1'b1;
    end

    // Any cycle with chip select low is a bus cycle.
    assign wr_cycle = !cs_n && !rw;
    assign rd_cycle = !cs_n && rw;

    // Strobes are only live during a cycle of the matching kind.
    always_comb begin
        wr.strobe = addr_hot & {16{wr_cycle}};
        wr.data   = d_in;
        rd.strobe = addr_hot & {16{rd_cycle}};
    end

endmodule

// File: src/cia_io_ports.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CIA parallel ports and handshake
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module cia_io_ports (
    input  logic                   CNT,
    input  logic                   RESET_n,
    input  cia_types_pkg::cia_wr_t wr,
    input  cia_types_pkg::cia_rd_t rd,
    input  logic                   flag_n,
    output logic [7:0]             pa_out,
    output logic [7:0]             pa_dir,
    output logic [7:0]             pb_out,
    output logic [7:0]             pb_dir,
    output logic                   pc_n,
    output logic                   flag_falling
);

    logic [7:0] pra;
    logic [7:0] prb;
    logic [7:0] ddra;
    logic [7:0] ddrb;
    logic       flag_s;
    logic       flag_prev;
    logic       prb_access;

    // Data and direction registers.
    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n) begin
            pra  <= 8'h00;
            prb  <= 8'h00;
            ddra <= 8'h00;
            ddrb <= 8'h00;
        end else begin
            if (wr.strobe[cia_map_pkg::REG_PRA])
                pra <= wr.data;
            if (wr.strobe[cia_map_pkg::REG_PRB])
                prb <= wr.data;
            if (wr.strobe[cia_map_pkg::REG_DDRA])
                ddra <= wr.data;
            if (wr.strobe[cia_map_pkg::REG_DDRB])
                ddrb <= wr.data;
        end
    end

    // PC strobes low for one cycle after any port B access.
    assign prb_access = wr.strobe[cia_map_pkg::REG_PRB] || rd.strobe[cia_map_pkg::REG_PRB];

    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n) begin
            pc_n      <= 1'b1;
            flag_s    <= 1'b1;
            flag_prev <= 1'b1;
        end else begin
            pc_n      <= !prb_access;
            flag_s    <= flag_n;
            flag_prev <= flag_s;
        end
    end

    // High in the cycle after flag_n is first sampled low.
    assign flag_falling = flag_prev && !flag_s;

    assign pa_out = pra;
    assign pa_dir = ddra;
    assign pb_out = prb;
    assign pb_dir = ddrb;

endmodule

// File: src/cia_interval_timer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CIA 16-bit interval timer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module cia_interval_timer (
    input  logic                        CNT,
    input  logic                        RESET_n,
    input  cia_types_pkg::timer_bus_t   tbus,
    input  logic                        ext_underflow,
    output cia_types_pkg::timer_state_t state
);

    logic [15:0] latch;
    logic [15:0] counter;
    logic        running;
    logic        oneshot;
    logic        count_uf;
    logic        step;
    logic        underflow;
    logic        hi_load;

    // Count every cycle, or only on the other timer's underflow.
    assign step      = running && (!count_uf || ext_underflow);
    assign underflow = step && (counter == 16'd0);

    // High byte write reloads while stopped or in one-shot.
    assign hi_load = tbus.hi_wr && (!running || oneshot);

    // Reload latch.
    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n) begin
            latch <= 16'd0;
        end else if (tbus.lo_wr) begin
            latch[7:0] <= tbus.data;
        end else if (tbus.hi_wr) begin
            latch[15:8] <= tbus.data;
        end
    end

    // Counter: force load first, then high byte load, then counting.
    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n) begin
            counter <= 16'd0;
        end else if (tbus.cr_wr && tbus.data[cia_map_pkg::CR_LOAD]) begin
            counter <= latch;
        end else if (hi_load) begin
            counter <= {tbus.data, latch[7:0]};
        end else if (underflow) begin
            counter <= latch;
        end else if (step) begin
            counter <= counter - 16'd1;
        end
    end

    // Control bits.
    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n) begin
            running  <= 1'b0;
            oneshot  <= 1'b0;
            count_uf <= 1'b0;
        end else if (tbus.cr_wr) begin
            running  <= tbus.data[cia_map_pkg::CR_START];
            oneshot  <= tbus.data[cia_map_pkg::CR_ONESHOT];
            count_uf <= tbus.data[cia_map_pkg::CR_INMODE_TA];
        end else if (tbus.hi_wr && oneshot) begin
            // One-shot starts on the high byte write.
            running <= 1'b1;
        end else if (underflow && oneshot) begin
            running <= 1'b0;
        end
    end

    assign state = '{
        counter:   counter,
        running:   running,
        oneshot:   oneshot,
        count_uf:  count_uf,
        underflow: underflow
    };

endmodule

// File: src/cia_irq_control.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CIA interrupt control register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module cia_irq_control (
    input  logic                                   CNT,
    input  logic                                   RESET_n,
    input  cia_types_pkg::cia_wr_t                 wr,
    input  cia_types_pkg::cia_rd_t                 rd,
    input  cia_types_pkg::irq_src_t                src,
    output logic [cia_map_pkg::IRQ_BITS-1:0]       icr_data,
    output logic                                   ir,
    output logic                                   irq_n
);

    logic [cia_map_pkg::IRQ_BITS-1:0] mask;
    logic [cia_map_pkg::IRQ_BITS-1:0] wr_bits;

    assign wr_bits = wr.data[cia_map_pkg::IRQ_BITS-1:0];

    // Set or clear the mask bits selected by the written byte.
    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n) begin
            mask <= '0;
        end else if (wr.strobe[cia_map_pkg::REG_ICR]) begin
            if (wr.data[cia_map_pkg::ICR_SET_CLR])
                mask <= mask | wr_bits;
            else
                mask <= mask & ~wr_bits;
        end
    end

    // Sources accumulate. A read drops old bits but keeps this cycle's.
    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n) begin
            icr_data <= '0;
        end else if (rd.strobe[cia_map_pkg::REG_ICR]) begin
            icr_data <= src.pulse;
        end else begin
            icr_data <= icr_data | src.pulse;
        end
    end

    assign ir    = |(icr_data & mask);
    assign irq_n = !ir;

endmodule

// File: src/cia_read_mux.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CIA read data select
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module cia_read_mux (
    input  cia_types_pkg::cia_rd_t           rd,
    input  logic [7:0]                       pa_in,
    input  logic [7:0]                       pb_in,
    input  logic [7:0]                       ddra,
    input  logic [7:0]                       ddrb,
    input  cia_types_pkg::timer_state_t      ta,
    input  cia_types_pkg::timer_state_t      tb,
    input  logic [cia_map_pkg::IRQ_BITS-1:0] icr_data,
    input  logic                             ir,
    output logic [7:0]                       d_out,
    output logic                             d_oe
);

    // Control byte rebuilt from timer state. Load is a strobe, reads zero.
    function automatic logic [7:0] ctrl_byte(input cia_types_pkg::timer_state_t s);
        logic [7:0] b;
        b                            = 8'h00;
        b[cia_map_pkg::CR_START]     = s.running;
        b[cia_map_pkg::CR_ONESHOT]   = s.oneshot;
        b[cia_map_pkg::CR_INMODE_TA] = s.count_uf;
        return b;
    endfunction

    always_comb begin
        d_out = 8'h00;
        if (rd.strobe[cia_map_pkg::REG_PRA])
            d_out = pa_in;
        if (rd.strobe[cia_map_pkg::REG_PRB])
            d_out = pb_in;
        if (rd.strobe[cia_map_pkg::REG_DDRA])
            d_out = ddra;
        if (rd.strobe[cia_map_pkg::REG_DDRB])
            d_out = ddrb;
        if (rd.strobe[cia_map_pkg::REG_TA_LO])
            d_out = ta.counter[7:0];
        if (rd.strobe[cia_map_pkg::REG_TA_HI])
            d_out = ta.counter[15:8];
        if (rd.strobe[cia_map_pkg::REG_TB_LO])
            d_out = tb.counter[7:0];
        if (rd.strobe[cia_map_pkg::REG_TB_HI])
            d_out = tb.counter[15:8];
        // Bit 7 flags a masked pending source.
        if (rd.strobe[cia_map_pkg::REG_ICR])
            d_out = {ir, 2'b00, icr_data};
        if (rd.strobe[cia_map_pkg::REG_CRA])
            d_out = ctrl_byte(ta);
        if (rd.strobe[cia_map_pkg::REG_CRB])
            d_out = ctrl_byte(tb);
    end

    // Drive the bus on any read, mapped or not.
    assign d_oe = |rd.strobe;

endmodule

// File: src/cia_core.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CIA register core top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module cia_core (
    input  logic       CNT,
    input  logic       RESET_n,
    input  logic       cs_n,
    input  logic       rw,
    input  logic [3:0] a,
    input  logic [7:0] d_in,
    output logic [7:0] d_out,
    output logic       d_oe,
    input  logic [7:0] pa_in,
    input  logic [7:0] pb_in,
    output logic [7:0] pa_out,
    output logic [7:0] pa_dir,
    output logic [7:0] pb_out,
    output logic [7:0] pb_dir,
    input  logic       flag_n,
    output logic       pc_n,
    output logic       irq_n
);

    cia_types_pkg::cia_wr_t           wr;
    cia_types_pkg::cia_rd_t           rd;
    cia_types_pkg::timer_bus_t        ta_bus;
    cia_types_pkg::timer_bus_t        tb_bus;
    cia_types_pkg::timer_state_t      ta_state;
    cia_types_pkg::timer_state_t      tb_state;
    cia_types_pkg::irq_src_t          irq_src;
    logic                             flag_falling;
    logic [cia_map_pkg::IRQ_BITS-1:0] icr_data;
    logic                             ir;

    cia_bus_decode u_decode (
        .cs_n (cs_n),
        .rw   (rw),
        .a    (a),
        .d_in (d_in),
        .wr   (wr),
        .rd   (rd)
    );

    cia_io_ports u_ports (
        .CNT          (CNT),
        .RESET_n      (RESET_n),
        .wr           (wr),
        .rd           (rd),
        .flag_n       (flag_n),
        .pa_out       (pa_out),
        .pa_dir       (pa_dir),
        .pb_out       (pb_out),
        .pb_dir       (pb_dir),
        .pc_n         (pc_n),
        .flag_falling (flag_falling)
    );

    // Timer A has no underflow input, so its CRA bit 6 is kept clear.
    assign ta_bus = '{
        lo_wr: wr.strobe[cia_map_pkg::REG_TA_LO],
        hi_wr: wr.strobe[cia_map_pkg::REG_TA_HI],
        cr_wr: wr.strobe[cia_map_pkg::REG_CRA],
        data:  wr.strobe[cia_map_pkg::REG_CRA] ? (wr.data & 8'hBF) : wr.data
    };

    assign tb_bus = '{
        lo_wr: wr.strobe[cia_map_pkg::REG_TB_LO],
        hi_wr: wr.strobe[cia_map_pkg::REG_TB_HI],
        cr_wr: wr.strobe[cia_map_pkg::REG_CRB],
        data:  wr.data
    };

    cia_interval_timer timer_a (
        .CNT           (CNT),
        .RESET_n       (RESET_n),
        .tbus          (ta_bus),
        .ext_underflow (1'b0),
        .state         (ta_state)
    );

    // Timer B can count timer A underflows.
    cia_interval_timer timer_b (
        .CNT           (CNT),
        .RESET_n       (RESET_n),
        .tbus          (tb_bus),
        .ext_underflow (ta_state.underflow),
        .state         (tb_state)
    );

    // Alarm and serial sources never fire.
    assign irq_src.pulse =
        (cia_map_pkg::IRQ_BITS'(ta_state.underflow) << cia_map_pkg::IRQ_TA) |
        (cia_map_pkg::IRQ_BITS'(tb_state.underflow) << cia_map_pkg::IRQ_TB) |
        (cia_map_pkg::IRQ_BITS'(flag_falling) << cia_map_pkg::IRQ_FLAG);

    cia_irq_control u_irq (
        .CNT      (CNT),
        .RESET_n  (RESET_n),
        .wr       (wr),
        .rd       (rd),
        .src      (irq_src),
        .icr_data (icr_data),
        .ir       (ir),
        .irq_n    (irq_n)
    );

    cia_read_mux u_read (
        .rd       (rd),
        .pa_in    (pa_in),
        .pb_in    (pb_in),
        .ddra     (pa_dir),
        .ddrb     (pb_dir),
        .ta       (ta_state),
        .tb       (tb_state),
        .icr_data (icr_data),
        .ir       (ir),
        .d_out    (d_out),
        .d_oe     (d_oe)
    );

endmodule

// File: include/cia_tb_table.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CIA testbench stimulus table
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CIA_TB_TABLE_SVH
`define CIA_TB_TABLE_SVH

// Columns: operation, address or output select, data or idle cycles, expected value.
// Each row is one cycle; a read sees state as of the edge that starts its cycle.
task automatic fill_table();
    fill_test = 4'd0;
    add_row(OP_OUT, SEL_PC, 8'h00, 8'h01);
    add_row(OP_OUT, SEL_IRQ, 8'h00, 8'h01);
    add_row(OP_OUT, SEL_DOE, 8'h00, 8'h00);
    add_row(OP_OUT, SEL_PA_DIR, 8'h00, 8'h00);
    add_row(OP_OUT, SEL_PB_DIR, 8'h00, 8'h00);
    add_row(OP_RD, cia_map_pkg::REG_TA_LO, 8'h00, 8'h00);
    add_row(OP_RD, cia_map_pkg::REG_TB_HI, 8'h00, 8'h00);
    add_row(OP_RD, cia_map_pkg::REG_CRA, 8'h00, 8'h00);

    fill_test = 4'd1;
    add_row(OP_PINS, 4'h0, 8'h00, 8'h00);
    add_row(OP_WR, cia_map_pkg::REG_DDRA, 8'hF0, 8'h00);
    add_row(OP_WR, cia_map_pkg::REG_PRA, 8'h5A, 8'h00);
    add_row(OP_WR, cia_map_pkg::REG_DDRB, 8'h0F, 8'h00);
    add_row(OP_WR, cia_map_pkg::REG_PRB, 8'hA5, 8'h00);
    add_row(OP_OUT, SEL_PA_DIR, 8'h00, 8'hF0);
    add_row(OP_OUT, SEL_PA_OUT, 8'h00, 8'h5A);
    add_row(OP_OUT, SEL_PB_DIR, 8'h00, 8'h0F);
    add_row(OP_OUT, SEL_PB_OUT, 8'h00, 8'hA5);
    add_row(OP_RD, cia_map_pkg::REG_DDRA, 8'h00, 8'hF0);
    add_row(OP_RD, cia_map_pkg::REG_DDRB, 8'h00, 8'h0F);
    add_row(OP_RDPIN, cia_map_pkg::REG_PRA, 8'h00, 8'h00);
    add_row(OP_RDPIN, cia_map_pkg::REG_PRB, 8'h00, 8'h00);

    // PC low only in the cycle after the PRB read. Flag sets ICR bit 4.
    fill_test = 4'd2;
    add_row(OP_IDLE, 4'h0, 8'd2, 8'h00);
    add_row(OP_OUT, SEL_PC, 8'h00, 8'h01);
    add_row(OP_RDPIN, cia_map_pkg::REG_PRB, 8'h00, 8'h00);
    add_row(OP_OUT, SEL_PC, 8'h00, 8'h00);
    add_row(OP_OUT, SEL_PC, 8'h00, 8'h01);
    add_row(OP_RD, cia_map_pkg::REG_ICR, 8'h00, 8'h00);
    add_row(OP_FLAG, 4'h0, 8'h00, 8'h00);
    add_row(OP_IDLE, 4'h0, 8'd2, 8'h00);
    add_row(OP_RD, cia_map_pkg::REG_ICR, 8'h00, 8'h10);
    add_row(OP_RD, cia_map_pkg::REG_ICR, 8'h00, 8'h00);
    add_row(OP_FLAG, 4'h0, 8'h01, 8'h00);

    // Latch 5 gives a period of 6 cycles.
    fill_test = 4'd3;
    add_row(OP_WR, cia_map_pkg::REG_TA_LO, 8'h05, 8'h00);
    add_row(OP_WR, cia_map_pkg::REG_TA_HI, 8'h00, 8'h00);
    add_row(OP_WR, cia_map_pkg::REG_CRA, 8'h11, 8'h00);
    add_row(OP_IDLE, 4'h0, 8'd3, 8'h00);
    add_row(OP_RD, cia_map_pkg::REG_TA_LO, 8'h00, 8'h02);
    add_row(OP_IDLE, 4'h0, 8'd4, 8'h00);
    add_row(OP_RD, cia_map_pkg::REG_TA_LO, 8'h00, 8'h03);
    add_row(OP_WR, cia_map_pkg::REG_CRA, 8'h00, 8'h00);
    add_row(OP_RD, cia_map_pkg::REG_ICR, 8'h00, 8'h01);

    // High byte write starts the one-shot with latch 3.
    fill_test = 4'd4;
    add_row(OP_WR, cia_map_pkg::REG_CRA, 8'h08, 8'h00);
    add_row(OP_WR, cia_map_pkg::REG_TA_LO, 8'h03, 8'h00);
    add_row(OP_WR, cia_map_pkg::REG_TA_HI, 8'h00, 8'h00);
    add_row(OP_IDLE, 4'h0, 8'd1, 8'h00);
    add_row(OP_RD, cia_map_pkg::REG_CRA, 8'h00, 8'h09);
    add_row(OP_IDLE, 4'h0, 8'd2, 8'h00);
    add_row(OP_RD, cia_map_pkg::REG_CRA, 8'h00, 8'h08);
    add_row(OP_RD, cia_map_pkg::REG_TA_LO, 8'h00, 8'h03);
    add_row(OP_RD, cia_map_pkg::REG_ICR, 8'h00, 8'h01);

    // Timer A period 4, timer B latch 2 underflows on the third A underflow.
    fill_test = 4'd5;
    add_row(OP_WR, cia_map_pkg::REG_TB_LO, 8'h02, 8'h00);
    add_row(OP_WR, cia_map_pkg::REG_TB_HI, 8'h00, 8'h00);
    add_row(OP_WR, cia_map_pkg::REG_CRB, 8'h51, 8'h00);
    add_row(OP_WR, cia_map_pkg::REG_CRA, 8'h11, 8'h00);
    add_row(OP_IDLE, 4'h0, 8'd5, 8'h00);
    add_row(OP_RD, cia_map_pkg::REG_TB_LO, 8'h00, 8'h01);
    add_row(OP_RD, cia_map_pkg::REG_ICR, 8'h00, 8'h01);
    add_row(OP_IDLE, 4'h0, 8'd5, 8'h00);
    add_row(OP_RD, cia_map_pkg::REG_TB_LO, 8'h00, 8'h02);
    add_row(OP_RD, cia_map_pkg::REG_ICR, 8'h00, 8'h03);
    add_row(OP_WR, cia_map_pkg::REG_CRA, 8'h00, 8'h00);
    add_row(OP_WR, cia_map_pkg::REG_CRB, 8'h00, 8'h00);

    fill_test = 4'd6;
    add_row(OP_FLAG, 4'h0, 8'h00, 8'h00);
    add_row(OP_IDLE, 4'h0, 8'd2, 8'h00);
    add_row(OP_OUT, SEL_IRQ, 8'h00, 8'h01);
    add_row(OP_WR, cia_map_pkg::REG_ICR, 8'h90, 8'h00);
    add_row(OP_OUT, SEL_IRQ, 8'h00, 8'h00);
    add_row(OP_RD, cia_map_pkg::REG_ICR, 8'h00, 8'h90);
    add_row(OP_OUT, SEL_IRQ, 8'h00, 8'h01);
    add_row(OP_FLAG, 4'h0, 8'h01, 8'h00);
    add_row(OP_FLAG, 4'h0, 8'h00, 8'h00);
    add_row(OP_IDLE, 4'h0, 8'd2, 8'h00);
    add_row(OP_OUT, SEL_IRQ, 8'h00, 8'h00);
    add_row(OP_WR, cia_map_pkg::REG_ICR, 8'h10, 8'h00);
    add_row(OP_OUT, SEL_IRQ, 8'h00, 8'h01);
    add_row(OP_RD, cia_map_pkg::REG_ICR, 8'h00, 8'h10);
    add_row(OP_FLAG, 4'h0, 8'h01, 8'h00);
endtask

`endif

// File: testbench/cia_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CIA register core testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module cia_tb;

    // Row operations.
    localparam logic [3:0] OP_WR    = 4'd0;
    localparam logic [3:0] OP_RD    = 4'd1;
    localparam logic [3:0] OP_RDPIN = 4'd2;
    localparam logic [3:0] OP_IDLE  = 4'd3;
    localparam logic [3:0] OP_PINS  = 4'd4;
    localparam logic [3:0] OP_FLAG  = 4'd5;
    localparam logic [3:0] OP_OUT   = 4'd6;

    // Output selects for OP_OUT rows.
    localparam logic [3:0] SEL_PA_OUT = 4'd0;
    localparam logic [3:0] SEL_PB_OUT = 4'd1;
    localparam logic [3:0] SEL_PA_DIR = 4'd2;
    localparam logic [3:0] SEL_PB_DIR = 4'd3;
    localparam logic [3:0] SEL_PC     = 4'd4;
    localparam logic [3:0] SEL_IRQ    = 4'd5;
    localparam logic [3:0] SEL_DOE    = 4'd6;

    typedef struct packed {
        logic [3:0] op;
        logic [3:0] addr;
        logic [7:0] data;
        logic [7:0] exp;
        logic [3:0] test;
    } row_t;

    logic       CNT;
    logic       RESET_n;
    logic       cs_n;
    logic       rw;
    logic [3:0] a;
    logic [7:0] d_in;
    logic [7:0] d_out;
    logic       d_oe;
    logic [7:0] pa_in;
    logic [7:0] pb_in;
    logic [7:0] pa_out;
    logic [7:0] pa_dir;
    logic [7:0] pb_out;
    logic [7:0] pb_dir;
    logic       flag_n;
    logic       pc_n;
    logic       irq_n;

    row_t       rows[$];
    logic [3:0] fill_test;
    bit         rows_loaded;
    int         pass_count;
    int         fail_count;
    int         test_fails;

    cia_core DUT (
        .CNT     (CNT),
        .RESET_n (RESET_n),
        .cs_n    (cs_n),
        .rw      (rw),
        .a       (a),
        .d_in    (d_in),
        .d_out   (d_out),
        .d_oe    (d_oe),
        .pa_in   (pa_in),
        .pb_in   (pb_in),
        .pa_out  (pa_out),
        .pa_dir  (pa_dir),
        .pb_out  (pb_out),
        .pb_dir  (pb_dir),
        .flag_n  (flag_n),
        .pc_n    (pc_n),
        .irq_n   (irq_n)
    );

    initial begin
        CNT = 1'b0;
        forever #20 CNT = ~CNT;
    end

    task automatic add_row(input logic [3:0] op, input logic [3:0] addr,
                           input logic [7:0] data, input logic [7:0] exp);
        rows.push_back('{op: op, addr: addr, data: data, exp: exp, test: fill_test});
    endtask

    `include "cia_tb_table.svh"

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            fail_count++;
            test_fails++;
        end else begin
            pass_count++;
        end
    endtask

    function automatic logic [7:0] select_output(input logic [3:0] sel);
        case (sel)
            SEL_PA_OUT: return pa_out;
            SEL_PB_OUT: return pb_out;
            SEL_PA_DIR: return pa_dir;
            SEL_PB_DIR: return pb_dir;
            SEL_PC:     return {7'b0, pc_n};
            SEL_IRQ:    return {7'b0, irq_n};
            default:    return {7'b0, d_oe};
        endcase
    endfunction

    function automatic string output_name(input logic [3:0] sel);
        case (sel)
            SEL_PA_OUT: return "pa_out";
            SEL_PB_OUT: return "pb_out";
            SEL_PA_DIR: return "pa_dir";
            SEL_PB_DIR: return "pb_dir";
            SEL_PC:     return "pc_n";
            SEL_IRQ:    return "irq_n";
            default:    return "d_oe";
        endcase
    endfunction

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd0:    return "reset values";
            4'd1:    return "port registers";
            4'd2:    return "pc strobe and flag";
            4'd3:    return "timer A continuous";
            4'd4:    return "timer A one-shot";
            4'd5:    return "timer B counts A underflows";
            default: return "interrupt mask";
        endcase
    endfunction

    // Each row lasts one cycle. An idle row lasts data cycles.
    // Starts 5 ns after an edge.
    task automatic apply_row(input row_t r);
        int          n;
        logic [31:0] rnd;
        logic [7:0]  pin_exp;
        cs_n = 1'b1;
        rw   = 1'b1;
        case (r.op)
            OP_WR: begin
                cs_n = 1'b0;
                rw   = 1'b0;
                a    = r.addr;
                d_in = r.data;
            end
            OP_RD, OP_RDPIN: begin
                cs_n = 1'b0;
                a    = r.addr;
            end
            OP_PINS: begin
                rnd   = $urandom;
                pa_in = rnd[7:0];
                rnd   = $urandom;
                pb_in = rnd[7:0];
            end
            OP_FLAG: flag_n = r.data[0];
            default: ;
        endcase
        n = (r.op == OP_IDLE) ? int'(r.data) : 1;
        @(negedge CNT);
        case (r.op)
            OP_RD: begin
                check_value("d_out", d_out, r.exp);
                check_value("d_oe", {7'b0, d_oe}, 8'h01);
            end
            OP_RDPIN: begin
                pin_exp = (r.addr == cia_map_pkg::REG_PRA) ? pa_in : pb_in;
                check_value("d_out", d_out, pin_exp);
            end
            OP_OUT: check_value(output_name(r.addr), select_output(r.addr), r.exp);
            default: ;
        endcase
        repeat (n) @(posedge CNT);
        #5;
    endtask

    task automatic report_test(input logic [3:0] id);
        if (test_fails == 0)
            $display("Test %0d %s: ok", id, test_name(id));
        else
            $display("Test %0d %s: %0d mismatches", id, test_name(id), test_fails);
        test_fails = 0;
    endtask

    initial begin
        RESET_n  = 1'b0;
        cs_n     = 1'b1;
        rw       = 1'b1;
        a        = 4'h0;
        d_in     = 8'h00;
        pa_in    = 8'h00;
        pb_in    = 8'h00;
        flag_n   = 1'b1;
        void'($urandom(23315));
        fill_table();
        rows_loaded = 1'b1;
        repeat (5) @(posedge CNT);
        #5;
        RESET_n = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
            if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test)
                report_test(rows[i].test);
        end
        $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Generous bound of 64 cycles per table row.
    initial begin
        wait (rows_loaded);
        #(rows.size() * 64 * 40);
        $display("Timeout: the register sequence did not complete in time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: list.f
+incdir+include
src/cia_map_pkg.sv
src/cia_types_pkg.sv
src/cia_bus_decode.sv
src/cia_io_ports.sv
src/cia_interval_timer.sv
src/cia_irq_control.sv
src/cia_read_mux.sv
src/cia_core.sv
testbench/cia_tb.sv

// File: Bender.yml
package:
  name: cia_core

sources:
  - files:
      - src/cia_map_pkg.sv
      - src/cia_types_pkg.sv
      - src/cia_bus_decode.sv
      - src/cia_io_ports.sv
      - src/cia_interval_timer.sv
      - src/cia_irq_control.sv
      - src/cia_read_mux.sv
      - src/cia_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/cia_tb.sv
